/* stream_repacker.f */
logic/repack_pkg.sv
logic/lane_xbar.sv
logic/lane_fifo.sv
logic/lane_decoder.sv
logic/word_packer.sv
logic/stream_repacker.sv
verification/clk_gen.sv
verification/stream_repacker_tb.sv

/* verification/stream_repacker_tb.sv */
// Testbench module stream_repacker_tb with stimulus, reference packing, output compare and tests.
`timescale 1ns/100ps

module stream_repacker_tb;

  import repack_pkg::*;

  localparam int TOTAL_BEATS = 6 + 40 + 26 + 60 + 40;   // Beats over all tests.
  localparam int CYCLE_LIMIT = TOTAL_BEATS * 4 + 200;

  logic clk_i;
  logic arst_n;
  logic [NUM_LANES-1:0][DATA_W-1:0] in_data;
  logic [NUM_LANES-1:0]             in_keep;
  logic                             in_last;
  logic                             in_valid;
  logic                             in_ready;
  logic [NUM_LANES-1:0][DATA_W-1:0] out_data;
  logic [NUM_LANES-1:0]             out_keep;
  logic                             out_last;
  logic                             out_valid;
  logic                             out_ready;
  logic [ERR_CNT_W-1:0]             drop_count;

  integer seed = 32'h914ca4a7;
  int     cycles = 0;
  int     errors = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     exp_drops = 0;                                  // Bad beats sent so far.
  bit     stall_en = 1'b0;                                // Random out_ready low periods.
  bit     gap_en = 1'b0;                                  // Random in_valid gaps.
  int     stall_left = 0;                                 // Cycles left in a low period.

  logic [31:0] beat_data [$];                             // Beats of the current test.
  logic [3:0]  beat_keep [$];
  logic        beat_last [$];
  logic [31:0] exp_data [$];                              // Expected output words.
  logic [3:0]  exp_keep [$];
  logic        exp_last [$];

  clk_gen clk_gen_inst (
    .clk_i  (clk_i),
    .arst_n (arst_n)
  );

  stream_repacker stream_repacker_inst (
    .clk_i      (clk_i),
    .arst_n     (arst_n),
    .in_data    (in_data),
    .in_keep    (in_keep),
    .in_last    (in_last),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_data   (out_data),
    .out_keep   (out_keep),
    .out_last   (out_last),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .drop_count (drop_count)
  );

  task automatic check(input string field, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, field, got, exp);
    end
  endtask

  // One run of ones, with no hole and not empty.
  function automatic bit is_contiguous(input logic [3:0] keep);
    int runs;
    runs = 0;
    for (int i = 0; i < 4; i++) begin
      if (keep[i] && (i == 0 || !keep[i-1])) runs++;     // Count run starts.
    end
    return runs == 1;
  endfunction

  function automatic logic [31:0] word_mask(input logic [3:0] keep);
    logic [31:0] mask;
    mask = '0;
    for (int i = 0; i < 4; i++) mask[8*i +: 8] = {8{keep[i]}};
    return mask;
  endfunction

  function automatic logic [3:0] rand_keep(input bit bad);
    int start;
    int len;
    if (bad) begin
      case ({$random(seed)} % 6)                          // Empty or holed masks.
        0:       return 4'b0000;
        1:       return 4'b0101;
        2:       return 4'b1001;
        3:       return 4'b1011;
        4:       return 4'b1101;
        default: return 4'b1010;
      endcase
    end
    start = {$random(seed)} % 4;
    len   = {$random(seed)} % (4 - start) + 1;
    return 4'(((1 << len) - 1) << start);
  endfunction

  function automatic void add_beat(input logic [31:0] data, input logic [3:0] keep, input bit last);
    beat_data.push_back(data);
    beat_keep.push_back(keep);
    beat_last.push_back(last);
  endfunction

  // Random beats. The final one is always valid and last so the packet closes.
  function automatic void gen_beats(input int n, input int bad_pct, input int last_pct);
    bit bad;
    bit last;
    for (int i = 0; i < n; i++) begin
      bad  = (i != n - 1) && ({$random(seed)} % 100 < bad_pct);
      last = (i == n - 1) || ({$random(seed)} % 100 < last_pct);
      add_beat($random(seed), rand_keep(bad), last);
    end
  endfunction

  // Reference packer. Kept bytes in lane order, then cut into fours and after each last.
  function automatic void build_expected();
    logic [ELEM_W-1:0] elems [$];
    logic [31:0]       word;
    logic [3:0]        keep;
    int                n;
    int                hi;
    for (int b = 0; b < beat_keep.size(); b++) begin
      if (!is_contiguous(beat_keep[b])) begin
        exp_drops++;                                      // Dropped with its last flag.
      end else begin
        for (int l = 0; l < 4; l++) if (beat_keep[b][l]) hi = l;
        for (int l = 0; l < 4; l++) begin
          if (beat_keep[b][l]) begin
            elems.push_back({beat_last[b] && (l == hi), beat_data[b][8*l +: 8]});
          end
        end
      end
    end
    n    = 0;
    word = '0;
    keep = '0;
    foreach (elems[e]) begin
      word[8*n +: 8] = elems[e][DATA_W-1:0];
      keep[n]        = 1'b1;
      n++;
      if (n == 4 || elems[e][LAST_BIT]) begin
        exp_data.push_back(word);
        exp_keep.push_back(keep);
        exp_last.push_back(elems[e][LAST_BIT]);
        n    = 0;
        word = '0;
        keep = '0;
      end
    end
  endfunction

  task automatic run_test(input string name);
    int errs_before;
    errs_before = errors;
    build_expected();
    for (int b = 0; b < beat_data.size(); b++) begin
      in_data  <= beat_data[b];
      in_keep  <= beat_keep[b];
      in_last  <= beat_last[b];
      in_valid <= 1'b1;
      @(posedge clk_i);
      while (!in_ready) @(posedge clk_i);               // Held until the handshake.
      if (gap_en && ({$random(seed)} % 3 == 0)) begin
        in_valid <= 1'b0;
        repeat ({$random(seed)} % 3 + 1) @(posedge clk_i);
      end
    end
    in_valid <= 1'b0;
    beat_data.delete();
    beat_keep.delete();
    beat_last.delete();
    while (exp_data.size() != 0) @(posedge clk_i);      // Drain every expected word.
    repeat (4) @(posedge clk_i);                          // Room for stray words and drop_count.
    check("drop_count", 32'(drop_count), 32'(exp_drops));
    if (errors == errs_before) begin
      pass_cnt++;
      $display("test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // Output handshake compare against the expected queue.
  always @(posedge clk_i) begin : compare_words
    if (arst_n && out_valid && out_ready) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("extra output word at %0t ns when no word was expected", $time);
      end else begin
        check("out_data", out_data & word_mask(exp_keep[0]), exp_data.pop_front());
        check("out_keep", 32'(out_keep), 32'(exp_keep.pop_front()));
        check("out_last", 32'(out_last), 32'(exp_last.pop_front()));
      end
    end
  end

  // Low periods of 8 to 23 cycles, long enough to fill the FIFO and stall the input.
  always @(posedge clk_i) begin
    if (stall_left != 0) begin
      out_ready  <= 1'b0;
      stall_left <= stall_left - 1;
    end else if (stall_en && ({$random(seed)} % 8 == 0)) begin
      out_ready  <= 1'b0;
      stall_left <= {$random(seed)} % 16 + 7;
    end else begin
      out_ready <= 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    in_data   = '0;
    in_keep   = '0;
    in_last   = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    @(posedge arst_n);
    @(posedge clk_i);
    check("out_valid after reset", 32'(out_valid), 32'd0);
    check("drop_count after reset", 32'(drop_count), 32'd0);
    check("in_ready after reset", 32'(in_ready), 32'd1);
    for (int p = 0; p < 3; p++) begin
      add_beat($random(seed), 4'b1111, 1'b0);
      add_beat($random(seed), 4'b1111, 1'b1);
    end
    run_test("full beats");
    gen_beats(40, 0, 0);
    run_test("partial keeps");
    add_beat($random(seed), 4'b1111, 1'b0);               // Five bytes, short tail.
    add_beat($random(seed), 4'b0001, 1'b1);
    add_beat($random(seed), 4'b0110, 1'b1);               // Two bytes alone.
    add_beat($random(seed), 4'b1000, 1'b0);
    add_beat($random(seed), 4'b0111, 1'b1);
    add_beat($random(seed), 4'b1110, 1'b1);
    gen_beats(20, 0, 30);
    run_test("packet ends");
    stall_en = 1'b1;
    gap_en   = 1'b1;
    gen_beats(60, 0, 20);
    run_test("back pressure and gaps");
    gen_beats(40, 30, 15);
    run_test("dropped beats");
    $display("summary: %0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* verification/clk_gen.sv */
// Clock and reset generator module clk_gen for the testbench.
`timescale 1ns/100ps

module clk_gen #(
  parameter int PERIOD_NS    = 8,                         // Clock period.
  parameter int RESET_CYCLES = 4                          // Cycles with reset held low.
) (
  output logic clk_i,
  output logic arst_n
);

  initial begin
    clk_i  = 1'b0;
    arst_n = 1'b0;                                        // Reset from time zero.
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n <= 1'b1;                                       // Release on an edge, after the flops sample.
  end

  always #(PERIOD_NS / 2) clk_i = ~clk_i;

endmodule

/* logic/stream_repacker.sv */
// Top level module stream_repacker joining decoder, element FIFO and word packer.
`timescale 1ns/100ps

module stream_repacker (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n,

  // Input stream.
  input  logic [repack_pkg::NUM_LANES-1:0][repack_pkg::DATA_W-1:0]  in_data,
  input  logic [repack_pkg::NUM_LANES-1:0]                          in_keep,
  input  logic                                                      in_last,
  input  logic                                                      in_valid,
  output logic                                                      in_ready,

  // Output stream.
  output logic [repack_pkg::NUM_LANES-1:0][repack_pkg::DATA_W-1:0]  out_data,
  output logic [repack_pkg::NUM_LANES-1:0]                          out_keep,
  output logic                                                      out_last,
  output logic                                                      out_valid,
  input  logic                                                      out_ready,

  output logic [repack_pkg::ERR_CNT_W-1:0]                          drop_count
);

  import repack_pkg::*;

  // Decoder to FIFO.
  logic [NUM_LANES-1:0][ELEM_W-1:0] dec_elems;
  logic [LANE_IDX_W-1:0]            dec_start_lane;
  logic [LANE_CNT_W-1:0]            dec_num_lanes;
  logic                             dec_valid;
  logic                             dec_ready;

  // FIFO to packer.
  logic [NUM_LANES-1:0][ELEM_W-1:0] fifo_data;
  logic [LEVEL_W-1:0]               fifo_level;
  logic                             fifo_valid;
  logic [LANE_CNT_W-1:0]            pop_num_lanes;
  logic                             pop_ready;

  lane_decoder lane_decoder_inst (
    .clk_i          (clk_i),
    .arst_n         (arst_n),
    .in_data        (in_data),
    .in_keep        (in_keep),
    .in_last        (in_last),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .dec_elems      (dec_elems),
    .dec_start_lane (dec_start_lane),
    .dec_num_lanes  (dec_num_lanes),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready),
    .drop_count     (drop_count)
  );

  lane_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) lane_fifo_inst (
    .clk_i           (clk_i),
    .arst_n          (arst_n),
    .push_num_lanes  (dec_num_lanes),
    .push_start_lane (dec_start_lane),
    .push_req_ok     (),                                   // Decoder forms in-range requests.
    .push_data       (dec_elems),
    .push_valid      (dec_valid),
    .push_ready      (dec_ready),
    .pop_num_lanes   (pop_num_lanes),
    .pop_start_lane  ('0),                                 // Output words start at lane 0.
    .pop_req_ok      (),
    .pop_data        (fifo_data),
    .pop_valid       (fifo_valid),
    .pop_ready       (pop_ready),
    .space_available (),
    .elem_available  (fifo_level)
  );

  word_packer word_packer_inst (
    .clk_i         (clk_i),
    .arst_n        (arst_n),
    .fifo_data     (fifo_data),
    .fifo_level    (fifo_level),
    .fifo_valid    (fifo_valid),
    .pop_num_lanes (pop_num_lanes),
    .pop_ready     (pop_ready),
    .out_data      (out_data),
    .out_keep      (out_keep),
    .out_last      (out_last),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

endmodule

/* logic/word_packer.sv */
// Output word builder module word_packer with pop size choice and output register.
`timescale 1ns/100ps

module word_packer (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n,

  // FIFO read side.
  input  logic [repack_pkg::NUM_LANES-1:0][repack_pkg::ELEM_W-1:0]  fifo_data,
  input  logic [repack_pkg::LEVEL_W-1:0]                            fifo_level,
  input  logic                                                      fifo_valid,
  output logic [repack_pkg::LANE_CNT_W-1:0]                         pop_num_lanes,
  output logic                                                      pop_ready,

  // Output stream.
  output logic [repack_pkg::NUM_LANES-1:0][repack_pkg::DATA_W-1:0]  out_data,
  output logic [repack_pkg::NUM_LANES-1:0]                          out_keep,
  output logic                                                      out_last,
  output logic                                                      out_valid,
  input  logic                                                      out_ready
);

  import repack_pkg::*;

  logic [LANE_CNT_W-1:0] pop_cnt;                          // Chosen group size.
  logic                  pop_last;                         // Group closes a packet.
  logic                  pop_fire;

  // Cut at the first stored last flag, else take a full word when one is there.
  always_comb begin
    pop_cnt  = (fifo_level >= NUM_LANES) ? LANE_CNT_W'(NUM_LANES) : '0;
    pop_last = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (!pop_last && (i < fifo_level) && fifo_data[i][LAST_BIT]) begin
        pop_cnt  = LANE_CNT_W'(i + 1);
        pop_last = 1'b1;                                   // Final popped element is last.
      end
    end
  end

  assign pop_num_lanes = pop_cnt;
  assign pop_ready     = !out_valid || out_ready;          // Register free or leaving.
  assign pop_fire      = fifo_valid && pop_ready;

  // Output word payload, unused lanes are zeroed.
  always_ff @(posedge clk_i) begin
    if (pop_fire) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        out_data[i] <= (i < pop_cnt) ? fifo_data[i][DATA_W-1:0] : '0;
        out_keep[i] <= (i < pop_cnt);
      end
      out_last <= pop_last;
    end
  end

  // Output valid flag.
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (pop_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;                                   // Word taken, nothing new.
    end
  end

endmodule

/* logic/lane_decoder.sv */
// Input beat register module lane_decoder with keep mask decode and drop counter.
`timescale 1ns/100ps

module lane_decoder (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n,

  // Input stream.
  input  logic [repack_pkg::NUM_LANES-1:0][repack_pkg::DATA_W-1:0]  in_data,
  input  logic [repack_pkg::NUM_LANES-1:0]                          in_keep,
  input  logic                                                      in_last,
  input  logic                                                      in_valid,
  output logic                                                      in_ready,

  // Request toward the FIFO.
  output logic [repack_pkg::NUM_LANES-1:0][repack_pkg::ELEM_W-1:0]  dec_elems,
  output logic [repack_pkg::LANE_IDX_W-1:0]                         dec_start_lane,
  output logic [repack_pkg::LANE_CNT_W-1:0]                         dec_num_lanes,
  output logic                                                      dec_valid,
  input  logic                                                      dec_ready,

  output logic [repack_pkg::ERR_CNT_W-1:0]                          drop_count
);

  import repack_pkg::*;

  logic [LANE_IDX_W-1:0]            first_lane;           // Lowest kept lane.
  logic [LANE_CNT_W-1:0]            run_len;              // Number of kept lanes.
  logic [NUM_LANES-1:0]             run_mask;             // Ideal mask for that run.
  logic                             any_keep;
  logic                             keep_ok;              // One contiguous run.
  logic [NUM_LANES-1:0][ELEM_W-1:0] elems;                // Tagged bytes.
  logic                             accept;

  // Keep mask decode.
  always_comb begin
    first_lane = '0;
    run_len    = '0;
    any_keep   = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (in_keep[i] && !any_keep) begin
        first_lane = LANE_IDX_W'(i);
        any_keep   = 1'b1;
      end
      run_len = run_len + LANE_CNT_W'(in_keep[i]);
    end
    run_mask = NUM_LANES'(((1 << run_len) - 1) << first_lane);
    keep_ok  = any_keep && (run_mask == in_keep);          // Holes break the match.
  end

  // Last goes only on the highest kept lane of a last beat.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      elems[i] = {in_last && (i == first_lane + run_len - 1), in_data[i]};
    end
  end

  assign in_ready = !dec_valid || dec_ready;               // Slot empty or draining.
  assign accept   = in_valid && in_ready;

  // Pipeline slot payload.
  always_ff @(posedge clk_i) begin
    if (accept && keep_ok) begin
      dec_elems      <= elems;
      dec_start_lane <= first_lane;
      dec_num_lanes  <= run_len;
    end
  end

  // Slot state and saturating drop counter.
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid  <= 1'b0;
      drop_count <= '0;
    end else begin
      if (accept) begin
        dec_valid <= keep_ok;                              // Bad beats never fill the slot.
      end else if (dec_ready) begin
        dec_valid <= 1'b0;
      end
      if (accept && !keep_ok && (drop_count != '1)) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

endmodule

/* logic/lane_fifo.sv */
// Variable-width element FIFO module lane_fifo with write and read lane rotation.
`timescale 1ns/100ps

module lane_fifo #(
  parameter int FIFO_DEPTH = repack_pkg::FIFO_DEPTH
) (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n,

  // Write side.
  input  logic [repack_pkg::LANE_CNT_W-1:0]                         push_num_lanes,
  input  logic [repack_pkg::LANE_IDX_W-1:0]                         push_start_lane,
  output logic                                                      push_req_ok,
  input  logic [repack_pkg::NUM_LANES-1:0][repack_pkg::ELEM_W-1:0]  push_data,
  input  logic                                                      push_valid,
  output logic                                                      push_ready,

  // Read side.
  input  logic [repack_pkg::LANE_CNT_W-1:0]                         pop_num_lanes,
  input  logic [repack_pkg::LANE_IDX_W-1:0]                         pop_start_lane,
  output logic                                                      pop_req_ok,
  output logic [repack_pkg::NUM_LANES-1:0][repack_pkg::ELEM_W-1:0]  pop_data,
  output logic                                                      pop_valid,
  input  logic                                                      pop_ready,

  // Occupancy.
  output logic [$clog2(FIFO_DEPTH+1)-1:0]                           space_available,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]                           elem_available
);

  import repack_pkg::*;

  typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] level_t;

  ptr_t   wr_ptr;                                          // Next free element slot.
  ptr_t   rd_ptr;                                          // Oldest stored element.
  level_t push_cnt;                                        // Elements written this cycle.
  level_t pop_cnt;                                         // Elements read this cycle.
  logic   push_fire;
  logic   pop_fire;

  logic [NUM_LANES-1:0][LANE_IDX_W-1:0] wr_sel;
  logic [NUM_LANES-1:0][LANE_IDX_W-1:0] rd_sel;
  logic [NUM_LANES-1:0][ELEM_W-1:0]     wr_lanes;          // Write data, packed at lane 0.
  logic [NUM_LANES-1:0][ELEM_W-1:0]     rd_lanes;          // Oldest elements in order.

  logic [ELEM_W-1:0] mem [FIFO_DEPTH];                     // Circular element store.

  // Pointer plus offset, wrapped at the depth.
  function automatic ptr_t wrap_add(input ptr_t base, input int unsigned ofs);
    int unsigned sum;
    sum = base + ofs;
    return (sum < FIFO_DEPTH) ? ptr_t'(sum) : ptr_t'(sum - FIFO_DEPTH);
  endfunction

  // Request range and space checks.
  assign push_req_ok = (push_start_lane + push_num_lanes) <= NUM_LANES;
  assign pop_req_ok  = (pop_start_lane + pop_num_lanes) <= NUM_LANES;
  assign space_available = level_t'(FIFO_DEPTH) - elem_available;
  assign push_ready = push_req_ok & (space_available >= push_num_lanes);
  assign pop_valid  = pop_req_ok & (pop_num_lanes != '0)
                    & (elem_available >= pop_num_lanes);   // Zero-size pops never fire.

  assign push_fire = push_valid & push_ready;
  assign pop_fire  = pop_valid & pop_ready;
  assign push_cnt  = push_fire ? level_t'(push_num_lanes) : '0;
  assign pop_cnt   = pop_fire ? level_t'(pop_num_lanes) : '0;

  // Crossbar selects. Write rotates the start lane down to 0, read rotates lane 0 up.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      wr_sel[i] = LANE_IDX_W'((i + push_start_lane) % NUM_LANES);
      rd_sel[i] = LANE_IDX_W'((i + NUM_LANES - pop_start_lane) % NUM_LANES);
    end
  end

  // Memory read window, always the oldest elements.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rd_lanes[i] = mem[wrap_add(rd_ptr, i)];
    end
  end

  lane_xbar wr_xbar_inst (
    .sel       (wr_sel),
    .lanes_in  (push_data),
    .lanes_out (wr_lanes)
  );

  lane_xbar rd_xbar_inst (
    .sel       (rd_sel),
    .lanes_in  (rd_lanes),
    .lanes_out (pop_data)
  );

  // Element store, only the requested lanes are written.
  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (i < push_num_lanes) begin
          mem[wrap_add(wr_ptr, i)] <= wr_lanes[i];
        end
      end
    end
  end

  // Pointers and fill level.
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      elem_available <= '0;
    end else begin
      elem_available <= elem_available + push_cnt - pop_cnt;  // Push and pop both apply.
      if (push_fire) begin
        wr_ptr <= wrap_add(wr_ptr, push_num_lanes);
      end
      if (pop_fire) begin
        rd_ptr <= wrap_add(rd_ptr, pop_num_lanes);
      end
    end
  end

endmodule

/* logic/lane_xbar.sv */
// Per-lane select crossbar module lane_xbar for element lanes.
`timescale 1ns/100ps

module lane_xbar (
  input  logic [repack_pkg::NUM_LANES-1:0][repack_pkg::LANE_IDX_W-1:0] sel,
  input  logic [repack_pkg::NUM_LANES-1:0][repack_pkg::ELEM_W-1:0]     lanes_in,
  output logic [repack_pkg::NUM_LANES-1:0][repack_pkg::ELEM_W-1:0]     lanes_out
);

  import repack_pkg::*;

  // Every output lane is a plain mux over all input lanes.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lanes_out[i] = lanes_in[sel[i]];                    // Pick the named input lane.
    end
  end

endmodule

/* logic/repack_pkg.sv */
// Shared lane, element, FIFO depth and counter width constants for the stream repacker.
package repack_pkg;

  // Stream geometry.
  localparam int NUM_LANES = 4;                           // Lanes per beat.
  localparam int DATA_W    = 8;                           // Bits per data byte.

  // Stored element layout.
  localparam int ELEM_W    = DATA_W + 1;                  // Byte plus its own last flag.
  localparam int LAST_BIT  = DATA_W;                      // Position of the last flag.

  // Element buffer.
  localparam int FIFO_DEPTH = 16;                         // Element capacity.

  // Derived widths.
  localparam int LANE_CNT_W = $clog2(NUM_LANES + 1);      // Lane count, 0 to NUM_LANES.
  localparam int LANE_IDX_W = $clog2(NUM_LANES);          // Lane index.
  localparam int LEVEL_W    = $clog2(FIFO_DEPTH + 1);     // Fill level, 0 to FIFO_DEPTH.

  // Status.
  localparam int ERR_CNT_W  = 8;                          // Dropped-beat counter width.

endpackage
